/* tb.f */
common/memPkg.sv
hdl/reqArbiter.sv
memCtrl/byteSequencer.sv
memCtrl/wordAssembler.sv
memCtrl/memCtrl.sv
hdl/byteRam.sv
hdl/memSubsystem.sv
tb/memSubsystemTb.sv

/* tb/memSubsystemTb.sv */
module memSubsystemTb;
    timeunit 1ns;
    timeprecision 1ps;
    import memPkg::*;

    localparam logic [AddrWidth-1:0] RegionA = 12'h100;
    localparam logic [AddrWidth-1:0] RegionB = 12'h800;
    localparam int NumStall = 40;
    localparam int NumRandom = 200;
    localparam int MaxStall = 8;
    localparam int NumAccesses = 26 + 12 + 4 + 4 + 7 + NumStall + NumRandom;
    localparam int TimeoutCycles = NumAccesses * (4 + 2 + MaxStall) + 1000;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 ioBufferFull;
    logic                 fetchEn;
    logic [AddrWidth-1:0] fetchAddr;
    logic                 fetchDone;
    logic [WordWidth-1:0] fetchInst;
    logic                 dataEn;
    logic                 dataStore;
    accLenT               dataLen;
    logic [AddrWidth-1:0] dataAddr;
    logic [WordWidth-1:0] dataWrData;
    logic                 dataDone;
    logic [WordWidth-1:0] dataRdData;

    logic [7:0]  shadow [RamDepth];
    logic [31:0] fetchExpQ [$];
    int          fetchDueQ [$];
    logic [31:0] dataExpQ [$];
    int          dataDueQ [$];
    logic [31:0] lfsrState = 32'h2018837d;
    int          cycleCount = 0;
    int          stallLeft = 0;
    logic [1:0]  stallSrc = 2'b11;
    logic        stallMode = 1'b0;
    logic        latencyCheck = 1'b0;
    logic        fetchBusy = 1'b0;
    logic        dataBusy = 1'b0;
    int          fetchDoneAt = 0;
    int          dataDoneAt = 0;
    string       testName = "reset";

    memSubsystem i_dut (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWrData   (dataWrData),
        .dataDone     (dataDone),
        .dataRdData   (dataRdData)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TimeoutCycles) begin
            $display("timeout after %0d cycles, requests never completed", cycleCount);
            $display("** FAIL **");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA3000000;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
        end
        return bits;
    endfunction

    function automatic accLenT randLen();
        logic [1:0] pick;
        pick = 2'(takeBits(2));
        case (pick)
            2'd0: return LenByte;
            2'd1: return LenHalf;
            default: return LenWord;
        endcase
    endfunction

    // little endian, zero above the bytes read
    function automatic logic [31:0] expectRead(input logic [AddrWidth-1:0] addr, input int n);
        logic [31:0]          word;
        logic [AddrWidth-1:0] a;
        word = '0;
        for (int i = 0; i < n; i++) begin
            a = addr + i;
            word[8*i +: 8] = shadow[a];
        end
        return word;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: %s expected %h actual %h", testName, what, expected, actual);
            $display("** FAIL **");
            $fatal(1, "mismatch");
        end
    endtask

    always @(negedge clk) begin : compare
        logic [31:0] expWord;
        int          due;
        if (!rst && fetchDone) begin
            if (fetchExpQ.size() == 0) begin
                $display("fetch done pulse arrived with no fetch outstanding");
                $display("** FAIL **");
                $fatal(1, "unexpected fetch done");
            end else begin
                expWord = fetchExpQ.pop_front();
                due = fetchDueQ.pop_front();
                checkValue("fetchInst", expWord, fetchInst);
                if (due >= 0) begin
                    checkValue("fetch done cycle", due, cycleCount);
                end
            end
        end
        if (!rst && dataDone) begin
            if (dataExpQ.size() == 0) begin
                $display("data done pulse arrived with no data access outstanding");
                $display("** FAIL **");
                $fatal(1, "unexpected data done");
            end else begin
                expWord = dataExpQ.pop_front();
                due = dataDueQ.pop_front();
                checkValue("dataRdData", expWord, dataRdData);
                if (due >= 0) begin
                    checkValue("data done cycle", due, cycleCount);
                end
            end
        end
    end

    // advance to the next falling edge, end strobes, update stall
    task automatic tick();
        logic [1:0] src;
        @(negedge clk);
        fetchEn = 1'b0;
        dataEn = 1'b0;
        if (fetchDone) begin
            fetchBusy = 1'b0;
            fetchDoneAt = cycleCount;
        end
        if (dataDone) begin
            dataBusy = 1'b0;
            dataDoneAt = cycleCount;
        end
        if (stallLeft != 0) begin
            stallLeft--;
        end else if (stallMode && takeBits(2) == 32'd0) begin
            stallLeft = takeBits(3) + 1;
            src = 2'(takeBits(2));
            stallSrc = (src == 2'd0) ? 2'b11 : src;
        end
        rdy = !(stallLeft != 0 && stallSrc[0]);
        ioBufferFull = (stallLeft != 0) && stallSrc[1];
    endtask

    task automatic issueData(input logic store, input accLenT len,
                             input logic [AddrWidth-1:0] addr, input logic [31:0] wdata);
        logic [AddrWidth-1:0] a;
        int                   n;
        n = int'(len);
        if (store) begin
            for (int i = 0; i < n; i++) begin
                a = addr + i;
                shadow[a] = wdata[8*i +: 8];
            end
            dataExpQ.push_back('0);
            // done one cycle after the last write lands, same as a read
            dataDueQ.push_back(latencyCheck ? cycleCount + n + 3 : -1);
        end else begin
            dataExpQ.push_back(expectRead(addr, n));
            dataDueQ.push_back(latencyCheck ? cycleCount + n + 3 : -1);
        end
        dataEn = 1'b1;
        dataStore = store;
        dataLen = len;
        dataAddr = addr;
        dataWrData = wdata;
        dataBusy = 1'b1;
    endtask

    task automatic issueFetch(input logic [AddrWidth-1:0] addr);
        fetchExpQ.push_back(expectRead(addr, 4));
        fetchDueQ.push_back(latencyCheck ? cycleCount + 4 + 3 : -1);
        fetchEn = 1'b1;
        fetchAddr = addr;
        fetchBusy = 1'b1;
    endtask

    task automatic waitIdle();
        while (fetchBusy || dataBusy) begin
            tick();
        end
    endtask

    task automatic dataAccess(input logic store, input accLenT len,
                              input logic [AddrWidth-1:0] addr, input logic [31:0] wdata);
        tick();
        issueData(store, len, addr, wdata);
        waitIdle();
    endtask

    // refill a port as soon as it is free
    task automatic randomTraffic(input int count);
        int                   issued;
        logic                 store;
        accLenT               len;
        logic [AddrWidth-1:0] addr;
        logic [31:0]          wdata;
        issued = 0;
        while (issued < count) begin
            tick();
            if (!dataBusy && issued < count) begin
                store = 1'(takeBits(1));
                len = randLen();
                addr = RegionA + AddrWidth'(takeBits(6));
                wdata = takeBits(32);
                issueData(store, len, addr, wdata);
                issued++;
            end
            if (!fetchBusy && issued < count) begin
                addr = RegionB + AddrWidth'(takeBits(5));
                issueFetch(addr);
                issued++;
            end
        end
        waitIdle();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = LenWord;
        dataAddr = '0;
        dataWrData = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // fill both working regions so no read sees unwritten bytes
        testName = "init";
        for (int i = 0; i < 17; i++) begin
            dataAccess(1'b1, LenWord, RegionA + 4 * i, takeBits(32));
        end
        for (int i = 0; i < 9; i++) begin
            dataAccess(1'b1, LenWord, RegionB + 4 * i, takeBits(32));
        end

        testName = "stores then loads";
        dataAccess(1'b1, LenWord, RegionA + 8, 32'hdeadbeef);
        dataAccess(1'b1, LenHalf, RegionA + 9, 32'h00005a3c);
        dataAccess(1'b1, LenByte, RegionA + 11, 32'h000000e7);
        dataAccess(1'b0, LenWord, RegionA + 8, '0);
        dataAccess(1'b0, LenHalf, RegionA + 10, '0);
        dataAccess(1'b0, LenByte, RegionA + 9, '0);
        dataAccess(1'b0, LenWord, RegionA + 9, '0);
        dataAccess(1'b0, LenHalf, RegionA + 11, '0);
        dataAccess(1'b0, LenByte, RegionA + 8, '0);
        dataAccess(1'b0, LenWord, RegionA + 6, '0);
        dataAccess(1'b0, LenHalf, RegionA + 7, '0);
        dataAccess(1'b0, LenByte, RegionA + 12, '0);

        testName = "fetch";
        for (int i = 0; i < 4; i++) begin
            tick();
            issueFetch(RegionB + 7 * i);
            waitIdle();
        end

        testName = "priority";
        tick();
        issueData(1'b0, LenWord, RegionA + 20, '0);
        issueFetch(RegionB + 4);
        waitIdle();
        checkValue("data served first", 32'd1, {31'd0, dataDoneAt < fetchDoneAt});
        tick();
        issueData(1'b1, LenHalf, RegionA + 30, 32'h0000c0de);
        issueFetch(RegionB + 13);
        waitIdle();
        checkValue("data served first", 32'd1, {31'd0, dataDoneAt < fetchDoneAt});

        testName = "latency";
        latencyCheck = 1'b1;
        dataAccess(1'b1, LenByte, RegionA + 40, 32'h000000a5);
        dataAccess(1'b1, LenHalf, RegionA + 41, 32'h00001234);
        dataAccess(1'b1, LenWord, RegionA + 43, 32'h89abcdef);
        dataAccess(1'b0, LenByte, RegionA + 40, '0);
        dataAccess(1'b0, LenHalf, RegionA + 41, '0);
        dataAccess(1'b0, LenWord, RegionA + 43, '0);
        tick();
        issueFetch(RegionB + 2);
        waitIdle();
        latencyCheck = 1'b0;

        testName = "stall";
        stallMode = 1'b1;
        randomTraffic(NumStall);
        stallMode = 1'b0;
        waitIdle();

        testName = "random traffic";
        randomTraffic(NumRandom);

        $display("** PASS **");
        $finish;
    end

endmodule

/* hdl/memSubsystem.sv */
module memSubsystem (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         ioBufferFull,
    input  logic                         fetchEn,
    input  logic [memPkg::AddrWidth-1:0] fetchAddr,
    output logic                         fetchDone,
    output logic [memPkg::WordWidth-1:0] fetchInst,
    input  logic                         dataEn,
    input  logic                         dataStore,
    input  memPkg::accLenT               dataLen,
    input  logic [memPkg::AddrWidth-1:0] dataAddr,
    input  logic [memPkg::WordWidth-1:0] dataWrData,
    output logic                         dataDone,
    output logic [memPkg::WordWidth-1:0] dataRdData
);
    import memPkg::*;

    logic [AddrWidth-1:0] ramAddr;
    logic                 ramWe;
    logic [ByteWidth-1:0] ramWrByte;
    logic [ByteWidth-1:0] ramRdByte;

    memCtrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWrData   (dataWrData),
        .dataDone     (dataDone),
        .dataRdData   (dataRdData),
        .ramAddr      (ramAddr),
        .ramWe        (ramWe),
        .ramWrByte    (ramWrByte),
        .ramRdByte    (ramRdByte)
    );

    byteRam i_ram (
        .clk    (clk),
        .addr   (ramAddr),
        .we     (ramWe),
        .wrByte (ramWrByte),
        .rdByte (ramRdByte)
    );

endmodule

/* hdl/byteRam.sv */
module byteRam (
    input  logic                         clk,
    input  logic [memPkg::AddrWidth-1:0] addr,
    input  logic                         we,
    input  logic [memPkg::ByteWidth-1:0] wrByte,
    output logic [memPkg::ByteWidth-1:0] rdByte
);
    import memPkg::*;

    logic [ByteWidth-1:0] mem [RamDepth];

    // read returns the old byte when the same address is written
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wrByte;
        end
        rdByte <= mem[addr];
    end

endmodule

/* memCtrl/memCtrl.sv */
module memCtrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         ioBufferFull,
    input  logic                         fetchEn,
    input  logic [memPkg::AddrWidth-1:0] fetchAddr,
    output logic                         fetchDone,
    output logic [memPkg::WordWidth-1:0] fetchInst,
    input  logic                         dataEn,
    input  logic                         dataStore,
    input  memPkg::accLenT               dataLen,
    input  logic [memPkg::AddrWidth-1:0] dataAddr,
    input  logic [memPkg::WordWidth-1:0] dataWrData,
    output logic                         dataDone,
    output logic [memPkg::WordWidth-1:0] dataRdData,
    output logic [memPkg::AddrWidth-1:0] ramAddr,
    output logic                         ramWe,
    output logic [memPkg::ByteWidth-1:0] ramWrByte,
    input  logic [memPkg::ByteWidth-1:0] ramRdByte
);
    import memPkg::*;

    logic                    stall;
    logic                    start;
    reqKindT                 kind;
    logic [AddrWidth-1:0]    addr;
    accLenT                  len;
    logic [WordWidth-1:0]    wrData;
    logic                    seqIdle;
    logic                    byteRead;
    logic [ByteIdxWidth-1:0] byteIdx;
    logic                    lastByte;
    reqKindT                 readKind;
    logic                    storeDone;
    logic                    loadDone;
    logic [WordWidth-1:0]    loadData;

    // no new byte cycles while the core or the IO buffer holds us
    assign stall = !rdy || ioBufferFull;

    reqArbiter i_arbiter (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .dataEn     (dataEn),
        .dataStore  (dataStore),
        .dataLen    (dataLen),
        .dataAddr   (dataAddr),
        .dataWrData (dataWrData),
        .seqIdle    (seqIdle),
        .start      (start),
        .kind       (kind),
        .addr       (addr),
        .len        (len),
        .wrData     (wrData)
    );

    byteSequencer i_sequencer (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .start     (start),
        .kind      (kind),
        .addr      (addr),
        .len       (len),
        .wrData    (wrData),
        .seqIdle   (seqIdle),
        .ramAddr   (ramAddr),
        .ramWe     (ramWe),
        .ramWrByte (ramWrByte),
        .byteRead  (byteRead),
        .byteIdx   (byteIdx),
        .lastByte  (lastByte),
        .readKind  (readKind),
        .storeDone (storeDone)
    );

    wordAssembler i_assembler (
        .clk       (clk),
        .rst       (rst),
        .byteRead  (byteRead),
        .byteIdx   (byteIdx),
        .lastByte  (lastByte),
        .readKind  (readKind),
        .ramRdByte (ramRdByte),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .loadDone  (loadDone),
        .loadData  (loadData)
    );

    assign dataDone = storeDone || loadDone;
    // stores return nothing
    assign dataRdData = storeDone ? '0 : loadData;

endmodule

/* memCtrl/wordAssembler.sv */
module wordAssembler (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            byteRead,
    input  logic [memPkg::ByteIdxWidth-1:0] byteIdx,
    input  logic                            lastByte,
    input  memPkg::reqKindT                 readKind,
    input  logic [memPkg::ByteWidth-1:0]    ramRdByte,
    output logic                            fetchDone,
    output logic [memPkg::WordWidth-1:0]    fetchInst,
    output logic                            loadDone,
    output logic [memPkg::WordWidth-1:0]    loadData
);
    import memPkg::*;

    logic                    tagRead;
    logic                    tagLast;
    logic [ByteIdxWidth-1:0] tagIdx;
    reqKindT                 tagKind;
    logic [WordWidth-1:0]    accum;
    logic [WordWidth-1:0]    merged;
    logic                    wordDone;

    // tags lag one cycle to meet the RAM read data
    always_ff @(posedge clk) begin
        if (rst) begin
            tagRead <= 1'b0;
            tagLast <= 1'b0;
        end else begin
            tagRead <= byteRead;
            tagLast <= lastByte;
        end
    end

    always_ff @(posedge clk) begin
        tagIdx <= byteIdx;
        tagKind <= readKind;
    end

    // byte 0 starts a fresh word, upper lanes stay zero
    always_comb begin
        merged = (tagIdx == '0) ? '0 : accum;
        merged[tagIdx*ByteWidth +: ByteWidth] = ramRdByte;
    end

    assign wordDone = tagRead && tagLast;

    always_ff @(posedge clk) begin
        if (tagRead) begin
            accum <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchDone <= 1'b0;
            loadDone <= 1'b0;
        end else begin
            fetchDone <= wordDone && (tagKind == KindFetch);
            loadDone <= wordDone && (tagKind != KindFetch);
        end
    end

    always_ff @(posedge clk) begin
        if (wordDone) begin
            if (tagKind == KindFetch) begin
                fetchInst <= merged;
            end else begin
                loadData <= merged;
            end
        end
    end

    // each requester has one access in flight, so done is a single pulse
    fetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone);
    loadDonePulse: assert property (@(posedge clk) disable iff (rst)
        loadDone |=> !loadDone);

endmodule

/* memCtrl/byteSequencer.sv */
module byteSequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            stall,
    input  logic                            start,
    input  memPkg::reqKindT                 kind,
    input  logic [memPkg::AddrWidth-1:0]    addr,
    input  memPkg::accLenT                  len,
    input  logic [memPkg::WordWidth-1:0]    wrData,
    output logic                            seqIdle,
    output logic [memPkg::AddrWidth-1:0]    ramAddr,
    output logic                            ramWe,
    output logic [memPkg::ByteWidth-1:0]    ramWrByte,
    output logic                            byteRead,
    output logic [memPkg::ByteIdxWidth-1:0] byteIdx,
    output logic                            lastByte,
    output memPkg::reqKindT                 readKind,
    output logic                            storeDone
);
    import memPkg::*;

    logic                 busy;
    logic [2:0]           cnt;
    logic [2:0]           nextCnt;
    logic                 issue;
    logic                 storeLanded;
    logic [AddrWidth-1:0] baseAddr;
    accLenT               lenQ;
    reqKindT              kindQ;
    logic [WordWidth-1:0] wrDataQ;

    assign seqIdle = !busy;
    assign issue = busy && !stall;
    assign nextCnt = cnt + 3'd1;

    // byte 0 goes out on the same edge that takes the grant
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt <= 3'd0;
            ramWe <= 1'b0;
            byteRead <= 1'b0;
            lastByte <= 1'b0;
            storeLanded <= 1'b0;
            storeDone <= 1'b0;
        end else begin
            // last write lands on this edge, done one cycle later
            storeLanded <= ramWe && lastByte;
            storeDone <= storeLanded;
            if (start) begin
                busy <= (len != LenByte);
                cnt <= 3'd1;
                ramWe <= (kind == KindStore);
                byteRead <= (kind != KindStore);
                lastByte <= (len == LenByte);
            end else if (issue) begin
                busy <= (nextCnt != lenQ);
                cnt <= nextCnt;
                ramWe <= (kindQ == KindStore);
                byteRead <= (kindQ != KindStore);
                lastByte <= (nextCnt == lenQ);
            end else begin
                ramWe <= 1'b0;
                byteRead <= 1'b0;
                lastByte <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            baseAddr <= addr;
            lenQ <= len;
            kindQ <= kind;
            wrDataQ <= wrData;
            ramAddr <= addr;
            ramWrByte <= wrData[ByteWidth-1:0];
            byteIdx <= '0;
            readKind <= kind;
        end else if (issue) begin
            // little endian, address wraps at the top of the RAM
            ramAddr <= baseAddr + cnt;
            ramWrByte <= wrDataQ[cnt[ByteIdxWidth-1:0]*ByteWidth +: ByteWidth];
            byteIdx <= cnt[ByteIdxWidth-1:0];
        end
    end

    // arbiter must see seqIdle before granting
    noStartWhenBusy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

endmodule

/* hdl/reqArbiter.sv */
module reqArbiter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall,
    input  logic                         fetchEn,
    input  logic [memPkg::AddrWidth-1:0] fetchAddr,
    input  logic                         dataEn,
    input  logic                         dataStore,
    input  memPkg::accLenT               dataLen,
    input  logic [memPkg::AddrWidth-1:0] dataAddr,
    input  logic [memPkg::WordWidth-1:0] dataWrData,
    input  logic                         seqIdle,
    output logic                         start,
    output memPkg::reqKindT              kind,
    output logic [memPkg::AddrWidth-1:0] addr,
    output memPkg::accLenT               len,
    output logic [memPkg::WordWidth-1:0] wrData
);
    import memPkg::*;

    logic                 fetchValid;
    logic [AddrWidth-1:0] fetchAddrQ;
    logic                 dataValid;
    reqKindT              dataKindQ;
    accLenT               dataLenQ;
    logic [AddrWidth-1:0] dataAddrQ;
    logic [WordWidth-1:0] dataWrDataQ;
    logic                 grantData;
    logic                 grantFetch;

    assign start = seqIdle && !stall && (dataValid || fetchValid);
    assign grantData = start && dataValid;
    assign grantFetch = start && !dataValid;

    // data slot goes first
    always_comb begin
        if (dataValid) begin
            kind = dataKindQ;
            addr = dataAddrQ;
            len = dataLenQ;
        end else begin
            kind = KindFetch;
            addr = fetchAddrQ;
            len = LenWord;
        end
    end

    assign wrData = dataWrDataQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchValid <= 1'b0;
            dataValid <= 1'b0;
        end else begin
            if (fetchEn) begin
                fetchValid <= 1'b1;
            end else if (grantFetch) begin
                fetchValid <= 1'b0;
            end
            if (dataEn) begin
                dataValid <= 1'b1;
            end else if (grantData) begin
                dataValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchEn) begin
            fetchAddrQ <= fetchAddr;
        end
        if (dataEn) begin
            dataKindQ <= dataStore ? KindStore : KindLoad;
            dataLenQ <= dataLen;
            dataAddrQ <= dataAddr;
            dataWrDataQ <= dataWrData;
        end
    end

    // requesters wait for their done pulse before strobing again
    slotFreeOnFetch: assert property (@(posedge clk) disable iff (rst)
        fetchEn |-> !fetchValid);
    slotFreeOnData: assert property (@(posedge clk) disable iff (rst)
        dataEn |-> !dataValid);

    legalDataLen: assert property (@(posedge clk) disable iff (rst)
        dataEn |-> isLegalLen(dataLen));

endmodule

/* common/memPkg.sv */
package memPkg;

    // byte-addressed RAM, 4 KiB
    localparam int AddrWidth = 12;
    localparam int RamDepth = 2 ** AddrWidth;

    // instruction and data words
    localparam int WordWidth = 32;
    localparam int ByteWidth = 8;
    localparam int BytesPerWord = WordWidth / ByteWidth;
    localparam int ByteIdxWidth = $clog2(BytesPerWord);

    // value is the byte count itself
    typedef enum logic [2:0] {
        LenByte = 3'd1,
        LenHalf = 3'd2,
        LenWord = 3'd4
    } accLenT;

    typedef enum logic [1:0] {
        KindFetch = 2'd0,
        KindLoad  = 2'd1,
        KindStore = 2'd2
    } reqKindT;

    // anything but 1, 2 or 4 bytes is illegal
    function automatic logic isLegalLen(input logic [2:0] len);
        return (len == LenByte) || (len == LenHalf) || (len == LenWord);
    endfunction

endpackage
